// File: verilog/cnn_pkg.sv
package cnn_pkg;

	////////////////////////////////////////
	// Word widths, Q2.14 samples
	////////////////////////////////////////
	localparam int DATA_W = 16;
	localparam int ACC_W = 32;
	localparam int FRAC_W = 14;

	////////////////////////////////////////
	// Layer geometry
	////////////////////////////////////////
	localparam int CH_IN = 2;
	localparam int KDIM = 3;
	// One output pixel sums KDIM*KDIM taps per input channel
	localparam int TAPS = KDIM * KDIM * CH_IN;
	localparam int CH_OUT = 4;
	localparam int WOUT = 4;
	localparam int OUT_PIXELS = WOUT * WOUT;
	localparam int TOTAL_PIX = OUT_PIXELS * TAPS;

	typedef logic signed [DATA_W-1:0] pix_t;
	typedef logic signed [ACC_W-1:0] acc_t;
	typedef logic [4:0] tap_t;
	// One weight per output channel, lane 0 in the low word
	typedef logic [CH_OUT-1:0][DATA_W-1:0] wrow_t;

	// Per channel bias in Q4.28, added to the raw product sum
	localparam acc_t BIAS [CH_OUT] = '{
		32'sh0400_0000,
		32'shFE00_0000,
		32'sh0000_0000,
		32'sh0100_0000
	};

endpackage

// File: verilog/mem_pkg.sv
package mem_pkg;

	////////////////////////////////////////
	// Shared feature-map RAM
	////////////////////////////////////////
	// Holds OUT_PIXELS x CH_OUT results
	localparam int FMAP_DEPTH = 64;
	typedef logic [5:0] faddr_t;

	// Input credits handed to the host after reset
	localparam int FIFO_DEPTH = 8;

	////////////////////////////////////////
	// Arbiter requester indices
	////////////////////////////////////////
	localparam int REQ_LAYER = 0;
	localparam int REQ_HOST = 1;

endpackage

// File: verilog/fmap_if.sv
interface fmap_if;

	// Request side, held until gnt
	logic req;
	logic we;
	mem_pkg::faddr_t addr;
	cnn_pkg::pix_t wdata;

	// Grant is combinational, read data a cycle later
	logic gnt;
	logic rvalid;
	cnn_pkg::pix_t rdata;

	modport requester (
		output req, we, addr, wdata,
		input gnt, rvalid, rdata
	);

	modport arbiter (
		input req, we, addr, wdata,
		output gnt, rvalid, rdata
	);

endinterface

// File: verilog/kernel_rom.sv
module kernel_rom (
	input logic clk,
	input cnn_pkg::tap_t tap,
	output cnn_pkg::wrow_t wrow
);

	// Tap major, channel minor
	logic [cnn_pkg::DATA_W-1:0] rom [cnn_pkg::TAPS * cnn_pkg::CH_OUT];

	initial begin
		$readmemh("verilog/kernel_weights.mem", rom);
	end

	// One row of CH_OUT weights per cycle
	always_ff @(posedge clk) begin
		for (int c = 0; c < cnn_pkg::CH_OUT; c++) begin
			wrow[c] <= rom[int'(tap) * cnn_pkg::CH_OUT + c];
		end
	end

endmodule

// File: verilog/pix_fifo.sv
module pix_fifo (
	input logic clk,
	input logic rst,
	input logic push_valid,
	input cnn_pkg::pix_t push_data,
	output logic pop_valid,
	output cnn_pkg::pix_t pop_data,
	input logic pop_ready,
	output logic credit
);

	cnn_pkg::pix_t mem [mem_pkg::FIFO_DEPTH];
	logic [$clog2(mem_pkg::FIFO_DEPTH)-1:0] wr_ptr;
	logic [$clog2(mem_pkg::FIFO_DEPTH)-1:0] rd_ptr;
	logic [$clog2(mem_pkg::FIFO_DEPTH):0] count;
	logic pop_fire;

	assign pop_valid = (count != '0);
	assign pop_data = mem[rd_ptr];
	assign pop_fire = pop_valid && pop_ready;

	// Storage, host never pushes without a credit
	always_ff @(posedge clk) begin
		if (push_valid)
			mem[wr_ptr] <= push_data;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			credit <= 1'b0;
		end else begin
			if (push_valid)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop_fire)
				rd_ptr <= rd_ptr + 1'b1;
			// Occupancy
			case ({push_valid, pop_fire})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
			// One credit back per popped pixel
			credit <= pop_fire;
		end
	end

endmodule

// File: verilog/squeeze_layer.sv
module squeeze_layer (
	input logic clk,
	input logic rst,
	input logic start,
	input logic pop_valid,
	input cnn_pkg::pix_t pop_data,
	output logic pop_ready,
	output cnn_pkg::tap_t tap,
	input cnn_pkg::wrow_t wrow,
	fmap_if.requester mem,
	output logic done
);

	logic run;
	cnn_pkg::tap_t tap_cnt;
	logic last_tap;
	logic pop_fire;
	logic [$clog2(cnn_pkg::OUT_PIXELS)-1:0] pix_cnt;
	// Pipeline stage aligned with the ROM output
	cnn_pkg::pix_t pix_q;
	logic v1;
	logic first1;
	logic last1;
	logic sum_done;
	cnn_pkg::acc_t acc [cnn_pkg::CH_OUT];
	cnn_pkg::pix_t res_buf [cnn_pkg::CH_OUT];
	logic busy;
	logic [$clog2(cnn_pkg::CH_OUT)-1:0] wr_ch;
	logic [$clog2(cnn_pkg::OUT_PIXELS)-1:0] wr_pix;

	assign last_tap = (tap_cnt == cnn_pkg::tap_t'(cnn_pkg::TAPS - 1));
	// Hold the last tap back while the result buffer still drains
	assign pop_ready = run && !(busy && last_tap);
	assign pop_fire = pop_valid && pop_ready;
	assign tap = tap_cnt;

	////////////////////////////////////////
	// Tap and pixel counters
	////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (rst) begin
			run <= 1'b0;
			tap_cnt <= '0;
			pix_cnt <= '0;
		end else if (start) begin
			run <= 1'b1;
			tap_cnt <= '0;
			pix_cnt <= '0;
		end else if (pop_fire) begin
			if (last_tap) begin
				tap_cnt <= '0;
				pix_cnt <= pix_cnt + 1'b1;
				// Stop popping after the final output pixel
				if (pix_cnt == $bits(pix_cnt)'(cnn_pkg::OUT_PIXELS - 1))
					run <= 1'b0;
			end else begin
				tap_cnt <= tap_cnt + 1'b1;
			end
		end
	end

	// Pixel lines up with the weight row next cycle
	always_ff @(posedge clk) begin
		if (pop_fire)
			pix_q <= pop_data;
	end

	always_ff @(posedge clk) begin
		if (rst || start) begin
			v1 <= 1'b0;
			first1 <= 1'b0;
			last1 <= 1'b0;
			sum_done <= 1'b0;
		end else begin
			v1 <= pop_fire;
			first1 <= pop_fire && (tap_cnt == '0);
			last1 <= pop_fire && last_tap;
			// Sum complete once the last product is in
			sum_done <= last1;
		end
	end

	////////////////////////////////////////
	// MAC lanes and bias/ReLU
	////////////////////////////////////////
	genvar g;
	generate
		for (g = 0; g < cnn_pkg::CH_OUT; g++) begin : g_lane
			cnn_pkg::pix_t w_lane;
			cnn_pkg::acc_t prod;
			cnn_pkg::acc_t sum;

			assign w_lane = wrow[g];
			assign prod = cnn_pkg::acc_t'(pix_q) * cnn_pkg::acc_t'(w_lane);
			assign sum = acc[g] + cnn_pkg::BIAS[g];

			// First tap clears, idle cycles hold
			always_ff @(posedge clk) begin
				if (v1)
					acc[g] <= first1 ? prod : acc[g] + prod;
			end

			// Negative goes to zero, else Q4.28 back to Q2.14
			always_ff @(posedge clk) begin
				if (sum_done)
					res_buf[g] <= sum[cnn_pkg::ACC_W-1] ? '0 :
						sum[cnn_pkg::FRAC_W+cnn_pkg::DATA_W-1:cnn_pkg::FRAC_W];
			end
		end
	endgenerate

	////////////////////////////////////////
	// Result writer
	////////////////////////////////////////
	assign mem.req = busy;
	assign mem.we = 1'b1;
	assign mem.addr = mem_pkg::faddr_t'(wr_pix * cnn_pkg::CH_OUT + wr_ch);
	assign mem.wdata = res_buf[wr_ch];

	always_ff @(posedge clk) begin
		if (rst || start) begin
			busy <= 1'b0;
			wr_ch <= '0;
			wr_pix <= '0;
			done <= 1'b0;
		end else if (sum_done) begin
			busy <= 1'b1;
			wr_ch <= '0;
		end else if (mem.gnt) begin
			wr_ch <= wr_ch + 1'b1;
			if (wr_ch == $bits(wr_ch)'(cnn_pkg::CH_OUT - 1)) begin
				busy <= 1'b0;
				wr_pix <= wr_pix + 1'b1;
				// Last word of the layer
				if (wr_pix == $bits(wr_pix)'(cnn_pkg::OUT_PIXELS - 1))
					done <= 1'b1;
			end
		end
	end

endmodule

// File: verilog/fmap_arbiter.sv
module fmap_arbiter (
	input logic clk,
	input logic rst,
	fmap_if.arbiter layer,
	fmap_if.arbiter host
);

	cnn_pkg::pix_t ram [mem_pkg::FMAP_DEPTH];
	cnn_pkg::pix_t rd_q;
	logic last_win;
	logic pick_host;
	logic any_gnt;
	logic sel_we;
	mem_pkg::faddr_t sel_addr;
	cnn_pkg::pix_t sel_wdata;
	logic layer_rv;
	logic host_rv;

	////////////////////////////////////////
	// Round robin grant
	////////////////////////////////////////
	// Host wins when alone or when the layer won last
	assign pick_host = host.req && (!layer.req || last_win == 1'(mem_pkg::REQ_LAYER));
	assign host.gnt = pick_host;
	assign layer.gnt = layer.req && !pick_host;
	assign any_gnt = layer.req || host.req;

	// Winner's request onto the RAM port
	assign sel_we = pick_host ? host.we : layer.we;
	assign sel_addr = pick_host ? host.addr : layer.addr;
	assign sel_wdata = pick_host ? host.wdata : layer.wdata;

	always_ff @(posedge clk) begin
		if (rst) begin
			last_win <= 1'(mem_pkg::REQ_HOST);
		end else if (any_gnt) begin
			last_win <= pick_host ? 1'(mem_pkg::REQ_HOST) : 1'(mem_pkg::REQ_LAYER);
		end
	end

	////////////////////////////////////////
	// RAM array
	////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (any_gnt) begin
			if (sel_we)
				ram[sel_addr] <= sel_wdata;
			else
				rd_q <= ram[sel_addr];
		end
	end

	// Read data valid only toward the requester that asked
	always_ff @(posedge clk) begin
		if (rst) begin
			layer_rv <= 1'b0;
			host_rv <= 1'b0;
		end else begin
			layer_rv <= layer.gnt && !layer.we;
			host_rv <= host.gnt && !host.we;
		end
	end

	assign layer.rvalid = layer_rv;
	assign host.rvalid = host_rv;
	assign layer.rdata = rd_q;
	assign host.rdata = rd_q;

endmodule

// File: verilog/squeeze_top.sv
module squeeze_top (
	input logic clk,
	input logic rst,
	input logic start,
	input logic pix_valid,
	input cnn_pkg::pix_t pix_data,
	output logic pix_credit,
	input logic rd_req,
	input mem_pkg::faddr_t rd_addr,
	output logic rd_gnt,
	output logic rd_valid,
	output cnn_pkg::pix_t rd_data,
	output logic done
);

	logic pop_valid;
	logic pop_ready;
	cnn_pkg::pix_t pop_data;
	cnn_pkg::tap_t tap;
	cnn_pkg::wrow_t wrow;

	fmap_if layer_if ();
	fmap_if host_if ();

	// Host read port, never writes
	assign host_if.req = rd_req;
	assign host_if.we = 1'b0;
	assign host_if.addr = rd_addr;
	assign host_if.wdata = '0;
	assign rd_gnt = host_if.gnt;
	assign rd_valid = host_if.rvalid;
	assign rd_data = host_if.rdata;

	pix_fifo u_fifo (
		.clk(clk),
		.rst(rst),
		.push_valid(pix_valid),
		.push_data(pix_data),
		.pop_valid(pop_valid),
		.pop_data(pop_data),
		.pop_ready(pop_ready),
		.credit(pix_credit)
	);

	kernel_rom u_rom (
		.clk(clk),
		.tap(tap),
		.wrow(wrow)
	);

	squeeze_layer u_layer (
		.clk(clk),
		.rst(rst),
		.start(start),
		.pop_valid(pop_valid),
		.pop_data(pop_data),
		.pop_ready(pop_ready),
		.tap(tap),
		.wrow(wrow),
		.mem(layer_if.requester),
		.done(done)
	);

	fmap_arbiter u_arb (
		.clk(clk),
		.rst(rst),
		.layer(layer_if.arbiter),
		.host(host_if.arbiter)
	);

endmodule

// File: tb/tb_clock.sv
module tb_clock (
	output logic clk
);

	timeunit 1ns;
	timeprecision 100ps;

	// 40 ns period
	localparam int HALF_NS = 20;

	initial begin
		clk = 1'b0;
		forever #(HALF_NS) clk = ~clk;
	end

endmodule

// File: tb/squeeze_tb.sv
module squeeze_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD = 40;
	localparam int NUM_ROWS = 4;
	localparam logic [31:0] SEED = 32'h7e0f866b;
	localparam int DONE_WAIT = 100;
	localparam int GNT_WAIT = 16;
	localparam int NWORDS = cnn_pkg::OUT_PIXELS * cnn_pkg::CH_OUT;
	localparam int NWEIGHTS = cnn_pkg::TAPS * cnn_pkg::CH_OUT;

	// Pixel mask, negative pixels, host reads in flight, pause odds in 16ths
	typedef struct packed {
		logic [15:0] mask;
		logic neg;
		logic reads;
		logic [3:0] gap;
	} row_t;

	localparam row_t ROWS [NUM_ROWS] = '{
		'{16'h3FFF, 1'b0, 1'b0, 4'd0},
		'{16'h1FFF, 1'b1, 1'b1, 4'd6},
		'{16'h7FFF, 1'b0, 1'b1, 4'd3},
		'{16'h0FFF, 1'b0, 1'b0, 4'd10}
	};

	logic clk;
	logic rst;
	logic start;
	logic pix_valid;
	cnn_pkg::pix_t pix_data;
	logic pix_credit;
	logic rd_req;
	mem_pkg::faddr_t rd_addr;
	logic rd_gnt;
	logic rd_valid;
	cnn_pkg::pix_t rd_data;
	logic done;

	// Two LFSR streams, pixels and gaps vs. in-flight reads
	logic [31:0] lfsr;
	logic [31:0] rd_lfsr;
	int sent;
	int returned;

	logic [15:0] wmem [NWEIGHTS];
	cnn_pkg::pix_t pixels [cnn_pkg::TOTAL_PIX];
	logic [15:0] model_out [NWORDS];
	logic neg_sum [NWORDS];

	tb_clock u_clock (
		.clk(clk)
	);

	squeeze_top dut (
		.clk(clk),
		.rst(rst),
		.start(start),
		.pix_valid(pix_valid),
		.pix_data(pix_data),
		.pix_credit(pix_credit),
		.rd_req(rd_req),
		.rd_addr(rd_addr),
		.rd_gnt(rd_gnt),
		.rd_valid(rd_valid),
		.rd_data(rd_data),
		.done(done)
	);

	////////////////////////////////////////
	// Reporting
	////////////////////////////////////////
	task automatic report_failure(input string why);
		$display("%s", why);
		$display("Finished with errors");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] want);
		if (actual !== want)
			report_failure($sformatf("ERROR %s: actual 0x%h, expected 0x%h", name, actual, want));
	endtask

	////////////////////////////////////////
	// Random stream
	////////////////////////////////////////
	// Fibonacci, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// One step per bit taken
	task automatic draw_bits(inout logic [31:0] state, input int n, output logic [31:0] bits);
		bits = '0;
		for (int k = 0; k < n; k++) begin
			state = lfsr_next(state);
			bits = {bits[30:0], state[0]};
		end
	endtask

	////////////////////////////////////////
	// Stimulus and reference model
	////////////////////////////////////////
	task automatic make_pixels(input row_t cfg);
		logic [31:0] r;
		cnn_pkg::pix_t v;
		for (int i = 0; i < cnn_pkg::TOTAL_PIX; i++) begin
			draw_bits(lfsr, 16, r);
			v = r[15:0] & cfg.mask;
			pixels[i] = cfg.neg ? -v : v;
		end
	endtask

	// Pixel index p*TAPS+t meets weight row t
	function automatic void build_model();
		cnn_pkg::acc_t sum;
		cnn_pkg::acc_t x;
		cnn_pkg::acc_t w;
		int idx;
		for (int p = 0; p < cnn_pkg::OUT_PIXELS; p++) begin
			for (int c = 0; c < cnn_pkg::CH_OUT; c++) begin
				sum = '0;
				for (int t = 0; t < cnn_pkg::TAPS; t++) begin
					x = pixels[p * cnn_pkg::TAPS + t];
					w = $signed(wmem[t * cnn_pkg::CH_OUT + c]);
					sum = sum + x * w;
				end
				sum = sum + cnn_pkg::BIAS[c];
				idx = p * cnn_pkg::CH_OUT + c;
				neg_sum[idx] = sum[31];
				// Negative to zero, else bits 29:14 without saturation
				model_out[idx] = sum[31] ? 16'h0000 : sum[29:14];
			end
		end
	endfunction

	// Words the ReLU must clamp to zero
	function automatic int count_negative();
		int n;
		n = 0;
		for (int a = 0; a < NWORDS; a++)
			if (neg_sum[a])
				n++;
		return n;
	endfunction

	// Called on a falling edge, returns on a falling edge
	task automatic read_word(input int addr, output logic [15:0] data);
		int waits;
		rd_req = 1'b1;
		rd_addr = mem_pkg::faddr_t'(addr);
		waits = 0;
		#1;
		while (!rd_gnt) begin
			waits++;
			if (waits > GNT_WAIT)
				report_failure("Host read was never granted by the arbiter");
			@(negedge clk);
			#1;
		end
		@(negedge clk);
		rd_req = 1'b0;
		if (!rd_valid)
			report_failure("Host read was granted but rd_valid stayed low");
		data = rd_data;
	endtask

	task automatic send_pixels(input row_t cfg);
		logic [31:0] r;
		int i;
		i = 0;
		while (i < cnn_pkg::TOTAL_PIX) begin
			@(negedge clk);
			pix_valid = 1'b0;
			if (done)
				report_failure("done rose before all pixels were sent");
			draw_bits(lfsr, 4, r);
			// Send only while a credit is held
			if (sent - returned < mem_pkg::FIFO_DEPTH && r[3:0] >= cfg.gap) begin
				pix_valid = 1'b1;
				pix_data = pixels[i];
				sent++;
				i++;
			end
		end
		@(negedge clk);
		pix_valid = 1'b0;
	endtask

	task automatic wait_for_done();
		int waits;
		waits = 0;
		while (!done) begin
			if (waits == DONE_WAIT)
				report_failure("done never rose after the last pixel was sent");
			@(negedge clk);
			waits++;
		end
	endtask

	task automatic read_during_run(input row_t cfg, input int base);
		logic [31:0] r;
		logic [15:0] d;
		int n;
		int a;
		while (cfg.reads && !done) begin
			draw_bits(rd_lfsr, 3, r);
			repeat (int'(r[2:0]) + 1) @(negedge clk);
			// Pixel p is written once the last tap of pixel p+1 was popped
			n = (returned - base) / cnn_pkg::TAPS - 1;
			if (n > 0 && !done) begin
				draw_bits(rd_lfsr, 6, r);
				a = int'(r[5:0]) % (n * cnn_pkg::CH_OUT);
				read_word(a, d);
				check_value($sformatf("rd_data[%0d] during run", a), 32'(d), 32'(model_out[a]));
			end
		end
	endtask

	task automatic read_back();
		logic [15:0] d;
		for (int a = 0; a < NWORDS; a++) begin
			read_word(a, d);
			if (!done)
				report_failure("done fell before the next start");
			check_value($sformatf("rd_data[%0d]", a), 32'(d), 32'(model_out[a]));
		end
	endtask

	task automatic run_row(input row_t cfg);
		logic [31:0] r;
		int base;
		make_pixels(cfg);
		build_model();
		// ReLU clamp path has to be exercised
		if (cfg.neg && count_negative() == 0)
			report_failure("Negative pixel row gives no negative sums to clamp");
		draw_bits(lfsr, 32, r);
		rd_lfsr = r | 32'h1;
		base = returned;
		@(negedge clk);
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		check_value("done", 32'(done), 32'h0);
		fork
			begin
				send_pixels(cfg);
				wait_for_done();
			end
			read_during_run(cfg, base);
		join
		read_back();
		// Every credit back home
		check_value("credits", mem_pkg::FIFO_DEPTH - (sent - returned), mem_pkg::FIFO_DEPTH);
	endtask

	////////////////////////////////////////
	// Credit return counter
	////////////////////////////////////////
	always @(posedge clk) begin
		if (!rst && pix_credit) begin
			returned = returned + 1;
			if (returned > sent)
				report_failure("Credit overflow, more credits returned than pixels sent");
		end
	end

	// Watchdog
	initial begin
		#(NUM_ROWS * cnn_pkg::TOTAL_PIX * 8 * CLK_PERIOD);
		report_failure("Watchdog timeout, the test rows did not finish in time");
	end

	initial begin
		rst = 1'b1;
		start = 1'b0;
		pix_valid = 1'b0;
		pix_data = '0;
		rd_req = 1'b0;
		rd_addr = '0;
		lfsr = SEED;
		rd_lfsr = SEED;
		$readmemh("verilog/kernel_weights.mem", wmem);
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		// Outputs quiet after reset
		check_value("done", 32'(done), 32'h0);
		check_value("pix_credit", 32'(pix_credit), 32'h0);
		check_value("rd_gnt", 32'(rd_gnt), 32'h0);
		check_value("rd_valid", 32'(rd_valid), 32'h0);
		for (int row = 0; row < NUM_ROWS; row++)
			run_row(ROWS[row]);
		$display("Finished with no errors");
		$finish;
	end

endmodule

// File: build.f
verilog/cnn_pkg.sv
verilog/mem_pkg.sv
verilog/fmap_if.sv
verilog/kernel_rom.sv
verilog/pix_fifo.sv
verilog/squeeze_layer.sv
verilog/fmap_arbiter.sv
verilog/squeeze_top.sv
tb/tb_clock.sv
tb/squeeze_tb.sv

// File: build.sh
#!/usr/bin/env bash
# Build and run the squeeze layer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module squeeze_tb -f build.f -o squeeze_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/squeeze_sim 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qxF "Finished with no errors" <<< "$output"; then
	exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// File: verilog/kernel_weights.mem
// Kernel weights in Q2.14, one 16-bit word per line, tap major then output channel
0A00
F800
0400
0200
0600
FC00
F600
0800
0300
0500
FA00
0100
F900
0700
0200
FE00
0C00
F400
0800
0300
0100
0200
FD00
0900
FB00
0600
0500
F700
0800
0100
F900
0400
0200
FA00
0A00
0500
0500
0300
0100
FC00
F700
0800
0600
0200
0400
FD00
F800
0700
0900
0200
0300
FB00
FE00
0A00
0400
0100
0300
F900
FC00
0600
0700
0400
0900
FD00
FA00
0100
0200
0800
0100
0600
F500
0300
